// ==== Makefile ====
SRCS := $(shell grep -v '^+' src.f) common/net_cfg_cfg.svh

run: obj_dir/Vtb_net_stack
	obj_dir/Vtb_net_stack | tee sim.log
	@! grep -q "Verification failed" sim.log
	@grep -q "Verification passed" sim.log

obj_dir/Vtb_net_stack: src.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_net_stack -f src.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== common/net_cfg_cfg.svh ====
`ifndef NET_CFG_CFG_SVH
`define NET_CFG_CFG_SVH

// 64-bit lanes in one user word
`define NET_LANES 8

// smallest frame in bytes, FCS excluded
`define NET_MIN_FRAME 60

// rx buffer depth in beats, power of two
`define NET_RX_DEPTH 16

// cycles spent in settle before the link comes up
`define NET_SETTLE_CYCLES 2

`endif

// ==== common/net_pkg.sv ====
`default_nettype none

`include "net_cfg_cfg.svh"

package net_pkg;

  // one MAC beat, byte 0 in data[7:0]
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  keep;  // contiguous from bit 0
    logic        last;  // end of frame
  } beat64_t;

  // one user word, lanes packed low to high
  typedef struct packed {
    logic [64*`NET_LANES-1:0] data;
    logic [8*`NET_LANES-1:0]  keep;
    logic                     last;
  } word512_t;

  typedef enum logic {
    PAD_PASS,
    PAD_FILL
  } pad_state_t;

  typedef enum logic [1:0] {
    SEQ_HOLD,
    SEQ_SETTLE,
    SEQ_UP
  } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/net_reset_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "net_cfg_cfg.svh"

module net_reset_seq (
  input  wire  sys_reset,
  input  wire  net_clk,
  input  wire  user_rx_reset,
  input  wire  user_tx_reset,
  output logic link_up
);
  import net_pkg::*;

  localparam int CNT_W = $clog2(`NET_SETTLE_CYCLES + 1);

  seq_state_t       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             mac_reset;

  assign mac_reset = user_rx_reset | user_tx_reset;  // either side still in reset
  assign link_up = (state_q == SEQ_UP);

  always_ff @(posedge sys_reset or posedge net_clk) begin
    if (net_clk) begin
      state_q <= SEQ_HOLD;
      cnt_q <= '0;
    end else begin
      case (state_q)
        SEQ_HOLD: begin
          cnt_q <= '0;
          if (!mac_reset) state_q <= SEQ_SETTLE;
        end
        SEQ_SETTLE: begin
          if (mac_reset) state_q <= SEQ_HOLD;  // restart the wait
          else if (cnt_q == CNT_W'(`NET_SETTLE_CYCLES)) state_q <= SEQ_UP;
          else cnt_q <= cnt_q + 1'b1;
        end
        default: begin
          if (mac_reset) state_q <= SEQ_HOLD;  // drop link on next edge
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/net_stack_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module net_stack_top (
  input  wire               sys_reset,
  input  wire               net_clk,
  input  wire               user_rx_reset,
  input  wire               user_tx_reset,
  output logic              network_init_done,
  output logic              rx_overflow,
  // user tx
  input  wire net_pkg::word512_t tx_word,
  input  wire               tx_valid,
  output logic              tx_ready,
  // user rx
  output net_pkg::word512_t rx_word,
  output logic              rx_valid,
  input  wire               rx_ready,
  // mac tx
  output net_pkg::beat64_t  mac_tx_beat,
  output logic              mac_tx_valid,
  input  wire               mac_tx_ready,
  // mac rx, no back-pressure
  input  wire net_pkg::beat64_t mac_rx_beat,
  input  wire               mac_rx_valid
);
  import net_pkg::*;

  beat64_t tx_mid_beat;  // converter to padding
  logic    tx_mid_valid;
  logic    tx_mid_ready;

  beat64_t rx_mid_beat;  // buffer to converter
  logic    rx_mid_valid;
  logic    rx_mid_ready;

  net_reset_seq i_reset_seq (
    .sys_reset     (sys_reset),
    .net_clk       (net_clk),
    .user_rx_reset (user_rx_reset),
    .user_tx_reset (user_tx_reset),
    .link_up       (network_init_done)
  );

  tx_width_down i_tx_width_down (
    .sys_reset (sys_reset),
    .net_clk   (net_clk),
    .in_word   (tx_word),
    .in_valid  (tx_valid),
    .in_ready  (tx_ready),
    .out_beat  (tx_mid_beat),
    .out_valid (tx_mid_valid),
    .out_ready (tx_mid_ready)
  );

  tx_frame_pad i_tx_frame_pad (
    .sys_reset (sys_reset),
    .net_clk   (net_clk),
    .link_up   (network_init_done),
    .in_beat   (tx_mid_beat),
    .in_valid  (tx_mid_valid),
    .in_ready  (tx_mid_ready),
    .mac_beat  (mac_tx_beat),
    .mac_valid (mac_tx_valid),
    .mac_ready (mac_tx_ready)
  );

  rx_beat_fifo i_rx_beat_fifo (
    .sys_reset (sys_reset),
    .net_clk   (net_clk),
    .link_up   (network_init_done),
    .in_beat   (mac_rx_beat),
    .in_valid  (mac_rx_valid),
    .out_beat  (rx_mid_beat),
    .out_valid (rx_mid_valid),
    .out_ready (rx_mid_ready),
    .overflow  (rx_overflow)
  );

  rx_width_up i_rx_width_up (
    .sys_reset (sys_reset),
    .net_clk   (net_clk),
    .in_beat   (rx_mid_beat),
    .in_valid  (rx_mid_valid),
    .in_ready  (rx_mid_ready),
    .out_word  (rx_word),
    .out_valid (rx_valid),
    .out_ready (rx_ready)
  );

endmodule

`default_nettype wire

// ==== rx_path/rx_beat_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "net_cfg_cfg.svh"

module rx_beat_fifo (
  input  wire                   sys_reset,
  input  wire                   net_clk,
  input  wire                   link_up,
  input  wire net_pkg::beat64_t in_beat,
  input  wire                   in_valid,
  output net_pkg::beat64_t      out_beat,
  output logic                  out_valid,
  input  wire                   out_ready,
  output logic                  overflow
);
  import net_pkg::*;

  localparam int PTR_W = $clog2(`NET_RX_DEPTH);

  beat64_t        mem [`NET_RX_DEPTH];
  logic [PTR_W:0] wr_ptr;  // extra msb tells full from empty
  logic [PTR_W:0] rd_ptr;
  logic           empty;
  logic           full;
  logic           arrive;
  logic           wr_en;
  logic           rd_en;

  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign arrive = in_valid & link_up;  // ignored while link is down
  assign wr_en = arrive & ~full;
  assign rd_en = out_valid & out_ready;

  assign out_valid = ~empty;
  assign out_beat = mem[rd_ptr[PTR_W-1:0]];

  always_ff @(posedge sys_reset or posedge net_clk) begin
    if (net_clk) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (arrive && full) overflow <= 1'b1;  // beat lost, sticky
    end
  end

  always_ff @(posedge sys_reset) begin
    if (wr_en) mem[wr_ptr[PTR_W-1:0]] <= in_beat;
  end

endmodule

`default_nettype wire

// ==== rx_path/rx_width_up.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "net_cfg_cfg.svh"

module rx_width_up (
  input  wire                   sys_reset,
  input  wire                   net_clk,
  input  wire net_pkg::beat64_t in_beat,
  input  wire                   in_valid,
  output logic                  in_ready,
  output net_pkg::word512_t     out_word,
  output logic                  out_valid,
  input  wire                   out_ready
);
  import net_pkg::*;

  localparam int LANE_W = $clog2(`NET_LANES);

  word512_t          word_q;
  word512_t          word_next;
  logic [LANE_W-1:0] lane_q;   // lane the next beat lands in
  logic              accept;
  logic              closing;

  assign in_ready = ~out_valid;  // stall while a word waits
  assign accept = in_valid & in_ready;
  assign closing = in_beat.last | (lane_q == LANE_W'(`NET_LANES - 1));
  assign out_word = word_q;

  always_comb begin
    if (lane_q == '0) begin
      word_next = '0;  // fresh word, unfilled lanes stay zero
    end else begin
      word_next = word_q;
    end
    word_next.data[64*lane_q +: 64] = in_beat.data;
    word_next.keep[8*lane_q +: 8] = in_beat.keep;
    word_next.last = in_beat.last;
  end

  always_ff @(posedge sys_reset or posedge net_clk) begin
    if (net_clk) begin
      lane_q <= '0;
      out_valid <= 1'b0;
    end else if (accept) begin
      if (closing) begin
        out_valid <= 1'b1;
        lane_q <= '0;
      end else begin
        lane_q <= lane_q + 1'b1;
      end
    end else if (out_valid && out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge sys_reset) begin
    if (accept) word_q <= word_next;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/net_pkg.sv
hw/net_reset_seq.sv
tx_path/tx_width_down.sv
tx_path/tx_frame_pad.sv
rx_path/rx_beat_fifo.sv
rx_path/rx_width_up.sv
hw/net_stack_top.sv
testbench/net_stack_props.sv
testbench/tb_net_stack.sv

// ==== testbench/net_stack_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module net_stack_props (
  input wire                    sys_reset,
  input wire                    net_clk,
  input wire                    network_init_done,
  input wire                    rx_overflow,
  input wire net_pkg::word512_t rx_word,
  input wire                    rx_valid,
  input wire                    rx_ready,
  input wire net_pkg::beat64_t  mac_tx_beat,
  input wire                    mac_tx_valid,
  input wire                    mac_tx_ready
);

  mac_tx_hold: assert property (@(posedge sys_reset) disable iff (net_clk)
    mac_tx_valid && !mac_tx_ready |=> mac_tx_valid && $stable(mac_tx_beat))
    else $error("mac tx beat changed while stalled");

  rx_word_hold: assert property (@(posedge sys_reset) disable iff (net_clk)
    rx_valid && !rx_ready |=> rx_valid && $stable(rx_word))
    else $error("user rx word changed while stalled");

  // no traffic before the link is up
  quiet_link_down: assert property (@(posedge sys_reset) disable iff (net_clk)
    !network_init_done |-> !mac_tx_valid && !rx_valid)
    else $error("stream valid while link down");

  overflow_sticky: assert property (@(posedge sys_reset) disable iff (net_clk)
    !$fell(rx_overflow))
    else $error("rx overflow cleared outside reset");

endmodule

bind net_stack_top net_stack_props i_props (
  .sys_reset         (sys_reset),
  .net_clk           (net_clk),
  .network_init_done (network_init_done),
  .rx_overflow       (rx_overflow),
  .rx_word           (rx_word),
  .rx_valid          (rx_valid),
  .rx_ready          (rx_ready),
  .mac_tx_beat       (mac_tx_beat),
  .mac_tx_valid      (mac_tx_valid),
  .mac_tx_ready      (mac_tx_ready)
);

`default_nettype wire

// ==== testbench/tb_net_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "net_cfg_cfg.svh"

module tb_net_stack;
  import net_pkg::*;

  localparam int TIMEOUT = 400;  // cycles any single wait may take
  localparam int CW = $bits(word512_t);

  logic        sys_reset;  // clock
  logic        net_clk;    // reset, active high
  logic        user_rx_reset;
  logic        user_tx_reset;
  logic        network_init_done;
  logic        rx_overflow;
  word512_t    tx_word;
  logic        tx_valid;
  logic        tx_ready;
  word512_t    rx_word;
  logic        rx_valid;
  logic        rx_ready;
  beat64_t     mac_tx_beat;
  logic        mac_tx_valid;
  logic        mac_tx_ready;
  beat64_t     mac_rx_beat;
  logic        mac_rx_valid;

  logic [15:0] lfsr_q;
  logic        rand_ready;  // mac model throttles tx
  logic        timed_out;
  int          err_count;
  int          check_count;
  logic [7:0]  exp_bytes[$];
  beat64_t     tx_seen[$];

  net_stack_top i_dut (
    .sys_reset         (sys_reset),
    .net_clk           (net_clk),
    .user_rx_reset     (user_rx_reset),
    .user_tx_reset     (user_tx_reset),
    .network_init_done (network_init_done),
    .rx_overflow       (rx_overflow),
    .tx_word           (tx_word),
    .tx_valid          (tx_valid),
    .tx_ready          (tx_ready),
    .rx_word           (rx_word),
    .rx_valid          (rx_valid),
    .rx_ready          (rx_ready),
    .mac_tx_beat       (mac_tx_beat),
    .mac_tx_valid      (mac_tx_valid),
    .mac_tx_ready      (mac_tx_ready),
    .mac_rx_beat       (mac_rx_beat),
    .mac_rx_valid      (mac_rx_valid)
  );

  initial begin
    sys_reset = 1'b0;
    forever #50 sys_reset = ~sys_reset;
  end

  task automatic check_eq(input logic [CW-1:0] got, input logic [CW-1:0] exp,
                          input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    err_count++;
    timed_out = 1'b1;
    $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
  endtask

  task automatic tick;
    @(posedge sys_reset);
    #1;
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) b[i] = rand_bit();
    return b;
  endfunction

  task automatic fill_payload(input int n);
    exp_bytes.delete();
    repeat (n) exp_bytes.push_back(rand_byte());
  endtask

  function automatic word512_t build_word(input int start, input int n, input logic last);
    word512_t w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w.data[8*i +: 8] = exp_bytes[start + i];
      w.keep[i] = 1'b1;
    end
    w.last = last;
    return w;
  endfunction

  function automatic beat64_t build_beat(input int start, input int n, input logic last);
    beat64_t b;
    b = '0;  // bytes past keep stay zero
    for (int i = 0; i < n; i++) begin
      b.data[8*i +: 8] = exp_bytes[start + i];
      b.keep[i] = 1'b1;
    end
    b.last = last;
    return b;
  endfunction

  // mac tx model, ready driven after the edge, beats taken at the falling edge
  always @(posedge sys_reset) begin
    #1;
    if (rand_ready) mac_tx_ready = rand_bit() | rand_bit();  // high 3 of 4 cycles
    else mac_tx_ready = 1'b1;
  end

  always @(negedge sys_reset) begin
    if (mac_tx_valid && mac_tx_ready) tx_seen.push_back(mac_tx_beat);
  end

  task automatic send_word(input word512_t w);
    int   n;
    logic fired;
    n = 0;
    fired = 1'b0;
    tx_word = w;
    tx_valid = 1'b1;
    while (!fired && n < TIMEOUT) begin
      @(negedge sys_reset);
      fired = tx_ready;
      tick;
      n++;
    end
    tx_valid = 1'b0;
    if (!fired) report_timeout("tx_ready for a user word");
  endtask

  task automatic wait_tx_frame;
    int   n;
    logic done;
    n = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      tick;
      done = (tx_seen.size() > 0) && tx_seen[$].last;
      n++;
    end
    if (!done) report_timeout("end of frame on MAC TX");
  endtask

  // beats must be full 8-byte beats except the final one
  task automatic check_mac_frame(input string name);
    int n_beats;
    int idx;
    int left;
    n_beats = (exp_bytes.size() + 7) / 8;
    idx = 0;
    check_eq(tx_seen.size(), n_beats, {name, " beat count"});
    foreach (tx_seen[b]) begin
      left = exp_bytes.size() - idx;
      if (left > 8) left = 8;
      if (left < 0) left = 0;
      check_eq(tx_seen[b].keep, 8'hFF >> (8 - left), $sformatf("%s beat %0d keep", name, b));
      check_eq(tx_seen[b].last, b == n_beats - 1, $sformatf("%s beat %0d last", name, b));
      for (int i = 0; i < left; i++) begin
        check_eq(tx_seen[b].data[8*i +: 8], exp_bytes[idx],
                 $sformatf("%s beat %0d byte %0d", name, b, i));
        idx++;
      end
    end
  endtask

  task automatic send_rx_beats(input int n_beats, input logic with_last);
    int n;
    for (int b = 0; b < n_beats; b++) begin
      n = exp_bytes.size() - 8*b;
      if (n > 8) n = 8;
      mac_rx_beat = build_beat(8*b, n, with_last && b == n_beats - 1);
      mac_rx_valid = 1'b1;
      tick;
    end
    mac_rx_valid = 1'b0;
    mac_rx_beat = '0;
  endtask

  // waits for a word, checks it holds while ready is low, then takes it
  task automatic recv_word(output word512_t w, input int hold);
    int   n;
    logic seen;
    n = 0;
    w = '0;
    @(negedge sys_reset);
    seen = rx_valid;
    while (!seen && n < TIMEOUT) begin
      @(negedge sys_reset);
      seen = rx_valid;
      n++;
    end
    if (!seen) begin
      report_timeout("user RX word");
    end else begin
      w = rx_word;
      repeat (hold) begin
        @(negedge sys_reset);
        check_eq(rx_valid, 1'b1, "rx_valid dropped without ready");
        check_eq(rx_word, w, "rx_word changed without ready");
      end
      tick;
      rx_ready = 1'b1;
      @(negedge sys_reset);
      check_eq(rx_valid, 1'b1, "rx_valid low at handshake");
    end
    tick;
    rx_ready = 1'b0;
  endtask

  task automatic bring_up_link;
    int n;
    for (int i = 0; i < 16; i++) begin
      @(negedge sys_reset);
      check_eq(network_init_done, 1'b0, "link up during reset");
      check_eq({mac_tx_valid, rx_valid, tx_ready, rx_overflow}, 4'b0, "output active in reset");
      tick;
      if (i == 8) user_rx_reset = 1'b0;
    end
    net_clk = 1'b0;
    for (int i = 0; i < 6; i++) begin
      @(negedge sys_reset);
      check_eq(network_init_done, 1'b0, "link up while tx reset held");
      tick;
    end
    user_tx_reset = 1'b0;
    for (int i = 0; i < `NET_SETTLE_CYCLES + 2; i++) begin
      @(negedge sys_reset);
      check_eq(network_init_done, 1'b0, "link up before settle time");
    end
    @(negedge sys_reset);
    check_eq(network_init_done, 1'b1, "link not up after settle time");
    tick;
    user_rx_reset = 1'b1;
    tick;
    @(negedge sys_reset);
    check_eq(network_init_done, 1'b0, "link still up after rx reset");
    tick;
    user_rx_reset = 1'b0;
    n = 0;
    while (!network_init_done && n < TIMEOUT) begin
      tick;
      n++;
    end
    if (!network_init_done) report_timeout("link up after rx reset pulse");
  endtask

  task automatic send_long_frame;
    fill_payload(130);
    tx_seen.delete();
    @(negedge sys_reset);
    rand_ready = 1'b1;
    tick;
    send_word(build_word(0, 64, 1'b0));
    send_word(build_word(64, 64, 1'b0));
    send_word(build_word(128, 2, 1'b1));  // keep 0x3 in the third word
    wait_tx_frame();
    @(negedge sys_reset);
    rand_ready = 1'b0;
    tick;
    check_mac_frame("long frame");
  endtask

  task automatic pad_short_frame;
    fill_payload(20);
    tx_seen.delete();
    send_word(build_word(0, 20, 1'b1));
    wait_tx_frame();
    while (exp_bytes.size() < `NET_MIN_FRAME) exp_bytes.push_back(8'h00);
    check_mac_frame("padded frame");
  endtask

  task automatic pack_rx_words;
    word512_t w;
    word512_t exp;
    fill_payload(86);  // 10 full beats and one of 6 bytes
    send_rx_beats(11, 1'b1);
    recv_word(w, 5);
    exp = build_word(0, 64, 1'b0);
    check_eq(w.data, exp.data, "rx word 0 data");
    check_eq(w.keep, exp.keep, "rx word 0 keep");
    check_eq(w.last, exp.last, "rx word 0 last");
    recv_word(w, 3);
    exp = build_word(64, 22, 1'b1);
    check_eq(w.data, exp.data, "rx word 1 data");
    check_eq(w.keep, exp.keep, "rx word 1 keep");
    check_eq(w.last, exp.last, "rx word 1 last");
  endtask

  task automatic overflow_rx_buffer;
    int n;
    int idle;
    int idx;
    fill_payload(240);
    @(negedge sys_reset);
    check_eq(rx_overflow, 1'b0, "overflow set before traffic");
    tick;
    send_rx_beats(30, 1'b1);
    repeat (4) begin
      @(negedge sys_reset);
      check_eq(rx_overflow, 1'b1, "overflow not set while buffer full");
    end
    tick;
    rx_ready = 1'b1;
    n = 0;
    idle = 0;
    idx = 0;
    while (idle < 20 && n < TIMEOUT) begin
      @(negedge sys_reset);
      if (rx_valid) begin
        idle = 0;
        for (int i = 0; i < 64; i++) begin
          if (rx_word.keep[i] && idx < exp_bytes.size()) begin
            check_eq(rx_word.data[8*i +: 8], exp_bytes[idx], $sformatf("rx byte %0d", idx));
            idx++;
          end
        end
      end else begin
        idle++;
      end
      n++;
    end
    tick;
    rx_ready = 1'b0;
    check_eq(idx > 0 && idx < exp_bytes.size(), 1'b1, "rx bytes not a proper prefix");
    check_eq(rx_overflow, 1'b1, "overflow cleared after draining");
  endtask

  initial begin
    net_clk = 1'b1;
    user_rx_reset = 1'b1;
    user_tx_reset = 1'b1;
    tx_word = '0;
    tx_valid = 1'b0;
    rx_ready = 1'b0;
    mac_tx_ready = 1'b1;
    mac_rx_beat = '0;
    mac_rx_valid = 1'b0;
    lfsr_q = 16'd15;
    rand_ready = 1'b0;
    timed_out = 1'b0;
    err_count = 0;
    check_count = 0;
    bring_up_link();
    if (!timed_out) send_long_frame();
    if (!timed_out) pad_short_frame();
    if (!timed_out) pack_rx_words();
    if (!timed_out) overflow_rx_buffer();
    $display("%0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tx_path/tx_frame_pad.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "net_cfg_cfg.svh"

module tx_frame_pad (
  input  wire                   sys_reset,
  input  wire                   net_clk,
  input  wire                   link_up,
  input  wire net_pkg::beat64_t in_beat,
  input  wire                   in_valid,
  output logic                  in_ready,
  output net_pkg::beat64_t      mac_beat,
  output logic                  mac_valid,
  input  wire                   mac_ready
);
  import net_pkg::*;

  localparam int CNT_W = $clog2(`NET_MIN_FRAME + 1);
  localparam logic [CNT_W:0] MIN_BYTES = (CNT_W + 1)'(`NET_MIN_FRAME);

  pad_state_t       state_q;
  logic [CNT_W-1:0] cnt_q;       // bytes sent so far, saturates at minimum
  logic [CNT_W:0]   rem;         // bytes still owed to reach the minimum
  logic [CNT_W:0]   sent;
  logic [3:0]       in_bytes;
  logic [3:0]       fill_n;
  logic [7:0]       fill_keep;
  logic [63:0]      byte_mask;
  logic             short_last;  // last beat that ends below the minimum

  assign in_bytes = 4'($countones(in_beat.keep));
  assign rem = MIN_BYTES - {1'b0, cnt_q};
  assign fill_n = (rem >= 8) ? 4'd8 : rem[3:0];
  assign fill_keep = ~(8'hFF << fill_n);
  assign short_last = in_beat.last && (({1'b0, cnt_q} + in_bytes) < MIN_BYTES);

  // original bytes survive only in pass mode
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      byte_mask[8*i +: 8] = {8{in_beat.keep[i] & (state_q == PAD_PASS)}};
    end
  end

  always_comb begin
    mac_beat = in_beat;
    if (state_q == PAD_FILL || short_last) begin
      mac_beat.data = in_beat.data & byte_mask;
      mac_beat.keep = fill_keep;
      mac_beat.last = (rem <= 8);  // minimum reached with this beat
    end
  end

  assign mac_valid = link_up & ((state_q == PAD_FILL) | in_valid);
  assign in_ready = link_up & (state_q == PAD_PASS) & mac_ready;
  assign sent = {1'b0, cnt_q} + 4'($countones(mac_beat.keep));

  always_ff @(posedge sys_reset or posedge net_clk) begin
    if (net_clk) begin
      state_q <= PAD_PASS;
      cnt_q <= '0;
    end else if (mac_valid && mac_ready) begin
      if (mac_beat.last) begin
        state_q <= PAD_PASS;
        cnt_q <= '0;
      end else begin
        if (short_last) state_q <= PAD_FILL;  // zero beats follow
        cnt_q <= (sent >= MIN_BYTES) ? MIN_BYTES[CNT_W-1:0] : sent[CNT_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== tx_path/tx_width_down.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "net_cfg_cfg.svh"

module tx_width_down (
  input  wire                    sys_reset,
  input  wire                    net_clk,
  input  wire net_pkg::word512_t in_word,
  input  wire                    in_valid,
  output logic                   in_ready,
  output net_pkg::beat64_t       out_beat,
  output logic                   out_valid,
  input  wire                    out_ready
);
  import net_pkg::*;

  localparam int LANE_W = $clog2(`NET_LANES);

  word512_t          word_q;
  logic [LANE_W-1:0] lane_q;     // lane now on the output
  logic [LANE_W-1:0] last_lane;
  logic              at_final;
  logic              ready_en;   // keeps ready low through reset

  // highest lane with any byte set, keep is contiguous
  always_comb begin
    last_lane = '0;
    for (int i = 0; i < `NET_LANES; i++) begin
      if (word_q.keep[8*i]) last_lane = LANE_W'(i);
    end
  end

  assign at_final = (lane_q == last_lane);

  assign out_beat = '{
    data: word_q.data[64*lane_q +: 64],
    keep: word_q.keep[8*lane_q +: 8],
    last: word_q.last & at_final
  };

  // take the next word as the final beat leaves
  assign in_ready = ready_en & (~out_valid | (out_ready & at_final));

  always_ff @(posedge sys_reset or posedge net_clk) begin
    if (net_clk) begin
      ready_en <= 1'b0;
      out_valid <= 1'b0;
      lane_q <= '0;
    end else begin
      ready_en <= 1'b1;
      if (in_valid && in_ready) begin
        out_valid <= 1'b1;
        lane_q <= '0;
      end else if (out_valid && out_ready) begin
        if (at_final) out_valid <= 1'b0;
        else lane_q <= lane_q + 1'b1;
      end
    end
  end

  always_ff @(posedge sys_reset) begin
    if (in_valid && in_ready) word_q <= in_word;  // held until the last lane goes
  end

endmodule

`default_nettype wire
